//--- cpuTop.f
hw/cpuPkg.sv
hw/pipeReg.sv
hw/hazardUnit.sv
hw/forwardUnit.sv
hw/executeStage.sv
hw/memStage.sv
hw/fetchDecode.sv
hw/cpuTop.sv
bench/tbMemory.sv
bench/tbTop.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build tbTop with Verilator, run it, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f cpuTop.f \
		-Mdir obj_dir -o tbTop
	./obj_dir/tbTop > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- bench/tbTop.sv
// testbench top: clock, reset, random program, instruction-set model, store checks, watchdog
`timescale 1ns/1ps

module tbTop;

	localparam int progLen = 64;
	localparam int initRegs = 7;
	localparam int busyAllowance = progLen * 20;
	localparam int watchdogCycles = 2 * (progLen * 40 + busyAllowance);

	logic DCACHE_stall;
	logic rst_n;
	logic busyEnable;
	logic [29:0] imemAddr;
	logic imemRen;
	cpuPkg::word_t imemData;
	logic imemBusy;
	cpuPkg::dmemReq_t dmemReq;
	cpuPkg::word_t dmemRdata;
	logic dmemBusy;
	logic wrFire;
	logic [29:0] wrAddr;
	cpuPkg::word_t wrData;

	integer seed;
	int valueErrors;
	int countErrors;
	int storeIdx;
	int endPasses;
	logic checking;
	cpuPkg::word_t prog [progLen];
	logic [29:0] expAddr [$];
	cpuPkg::word_t expData [$];

	initial DCACHE_stall = 1'b0;
	always #4 DCACHE_stall = ~DCACHE_stall;

	cpuTop #(
		.resetPc(32'h0)
	) i_dut (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.imemAddr(imemAddr),
		.imemRen(imemRen),
		.imemData(imemData),
		.imemBusy(imemBusy),
		.dmemReq(dmemReq),
		.dmemRdata(dmemRdata),
		.dmemBusy(dmemBusy)
	);

	tbMemory #(
		.seedInit(91)
	) i_mem (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.busyEnable(busyEnable),
		.imemAddr(imemAddr),
		.imemRen(imemRen),
		.imemData(imemData),
		.imemBusy(imemBusy),
		.dmemReq(dmemReq),
		.dmemRdata(dmemRdata),
		.dmemBusy(dmemBusy),
		.wrFire(wrFire),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	function automatic int randBelow(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic cpuPkg::word_t fillWord(input int idx);
		return 32'hc0de_0000 ^ (32'(idx) * 32'h0004_1031);
	endfunction

	function automatic cpuPkg::word_t rType(input logic [5:0] fn, input int rd, input int rs,
		input int rt);
		return {6'd0, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic cpuPkg::word_t iType(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [5:0] functFor(input int n);
		case (n)
			0: return 6'(cpuPkg::fnAdd);
			1: return 6'(cpuPkg::fnSub);
			2: return 6'(cpuPkg::fnAnd);
			3: return 6'(cpuPkg::fnOr);
			4: return 6'(cpuPkg::fnNor);
			default: return 6'(cpuPkg::fnSlt);
		endcase
	endfunction

	function automatic logic [5:0] immOpFor(input int n);
		case (n)
			0: return 6'(cpuPkg::opAddi);
			1: return 6'(cpuPkg::opAndi);
			2: return 6'(cpuPkg::opOri);
			3: return 6'(cpuPkg::opXori);
			default: return 6'(cpuPkg::opSlti);
		endcase
	endfunction

	// registers $0..$7 only, $1..$7 set up first
	task automatic buildProgram();
		int target;
		int rs;
		for (int i = 0; i < progLen; i++) begin
			target = i + 1 + randBelow(6);
			if (target > progLen - 1) begin
				target = progLen - 1;
			end
			rs = randBelow(8);
			if (i < initRegs) begin
				prog[i] = iType(6'(cpuPkg::opAddi), 0, i + 1, 16'($random(seed)));
			end else if (i == progLen - 1) begin
				prog[i] = {6'(cpuPkg::opJ), 26'(progLen - 1)};  // parks on itself
			end else begin
				case (randBelow(12))
					0, 1, 2, 3: prog[i] = rType(functFor(randBelow(6)), randBelow(8), rs,
						randBelow(8));
					4, 5, 6: prog[i] = iType(immOpFor(randBelow(5)), rs, randBelow(8),
						16'($random(seed)));
					7: prog[i] = iType(6'(cpuPkg::opLw), rs, randBelow(8), 16'($random(seed)));
					8, 9: prog[i] = iType(6'(cpuPkg::opSw), rs, randBelow(8), 16'($random(seed)));
					10: prog[i] = iType(6'(cpuPkg::opBeq), rs, randBelow(2) ? rs : randBelow(8),
						16'(target - i - 1));  // equal regs make it taken
					default: prog[i] = {6'(cpuPkg::opJ), 26'(target)};
				endcase
			end
		end
	endtask

	task automatic runModel();
		cpuPkg::word_t regs [32];
		cpuPkg::word_t mem [64];
		cpuPkg::word_t instr;
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		cpuPkg::word_t sext;
		cpuPkg::word_t zext;
		cpuPkg::word_t val;
		cpuPkg::word_t addr;
		logic [4:0] dest;
		logic doWrite;
		int pc;
		int nextPc;
		for (int k = 0; k < 32; k++) begin
			regs[k] = '0;
		end
		for (int k = 0; k < 64; k++) begin
			mem[k] = fillWord(k);
		end
		expAddr.delete();
		expData.delete();
		pc = 0;
		while (pc != progLen - 1) begin
			instr = prog[pc];
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			sext = {{16{instr[15]}}, instr[15:0]};
			zext = {16'h0, instr[15:0]};
			addr = a + sext;
			dest = instr[20:16];
			doWrite = 1'b1;
			val = '0;
			nextPc = pc + 1;
			case (instr[31:26])
				cpuPkg::opRtype: begin
					dest = instr[15:11];
					case (instr[5:0])
						cpuPkg::fnAdd: val = a + b;
						cpuPkg::fnSub: val = a - b;
						cpuPkg::fnAnd: val = a & b;
						cpuPkg::fnOr: val = a | b;
						cpuPkg::fnNor: val = ~(a | b);
						cpuPkg::fnSlt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: doWrite = 1'b0;
					endcase
				end
				cpuPkg::opAddi: val = a + sext;
				cpuPkg::opSlti: val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
				cpuPkg::opAndi: val = a & zext;
				cpuPkg::opOri: val = a | zext;
				cpuPkg::opXori: val = a ^ zext;
				cpuPkg::opLw: val = mem[addr[7:2]];  // memory model keeps 64 words
				cpuPkg::opSw: begin
					doWrite = 1'b0;
					expAddr.push_back(addr[31:2]);
					expData.push_back(b);
					mem[addr[7:2]] = b;
				end
				cpuPkg::opBeq: begin
					doWrite = 1'b0;
					if (a == b) begin
						nextPc = pc + 1 + int'(instr[15:0]);
					end
				end
				cpuPkg::opJ: begin
					doWrite = 1'b0;
					nextPc = int'(instr[25:0]);
				end
				default: doWrite = 1'b0;
			endcase
			if (doWrite && dest != 5'd0) begin
				regs[dest] = val;
			end
			pc = nextPc;
		end
	endtask

	task automatic loadMemories();
		for (int k = 0; k < 128; k++) begin
			i_mem.imem[k] = (k < progLen) ? prog[k] : '0;
		end
		for (int k = 0; k < 64; k++) begin
			i_mem.dmem[k] = fillWord(k);
		end
	endtask

	task automatic runPhase(input logic withBusy);
		@(posedge DCACHE_stall);
		rst_n <= 1'b0;
		busyEnable <= withBusy;
		@(posedge DCACHE_stall);
		loadMemories();
		repeat (2) @(posedge DCACHE_stall);
		if (imemRen || dmemReq.ren || dmemReq.wen) begin
			$display("%0t: a memory request is active while reset is held", $time);
			countErrors++;
		end
		storeIdx = 0;
		endPasses = 0;
		rst_n <= 1'b1;
		@(negedge DCACHE_stall);
		checking = 1'b1;
		@(negedge DCACHE_stall);
		if (!imemRen) begin
			$display("%0t: instruction fetch did not start on the first cycle out of reset",
				$time);
			countErrors++;
		end
		while (endPasses < 3) begin  // older stores drain while the final j loops
			@(negedge DCACHE_stall);
		end
		checking = 1'b0;
		if (storeIdx != expAddr.size()) begin
			$display("%0t: run with busy=%0b committed %0d stores but the model expects %0d",
				$time, withBusy, storeIdx, expAddr.size());
			countErrors++;
		end
	endtask

	always @(posedge DCACHE_stall) begin
		if (checking && wrFire) begin
			if (storeIdx >= expAddr.size()) begin
				$display("%0t: extra store to word address %h beyond the expected sequence",
					$time, wrAddr);
				countErrors++;
			end else if (wrAddr != expAddr[storeIdx] || wrData != expData[storeIdx]) begin
				$display("MISMATCH %0t: store %0d wrote %h to %h, expected %h to %h", $time,
					storeIdx, wrData, wrAddr, expData[storeIdx], expAddr[storeIdx]);
				valueErrors++;
			end
			storeIdx++;
		end
		if (checking && !imemBusy && !dmemBusy && imemAddr == 30'(progLen)) begin
			endPasses++;  // final j sits in decode
		end
	end

	initial begin
		seed = 91;
		rst_n = 1'b0;
		busyEnable = 1'b0;
		checking = 1'b0;
		valueErrors = 0;
		countErrors = 0;
		storeIdx = 0;
		endPasses = 0;
		buildProgram();
		runModel();
		runPhase(1'b0);
		runPhase(1'b1);
		$display("errors: %0d value mismatches, %0d sequence errors, %0d stores per run",
			valueErrors, countErrors, expAddr.size());
		if (valueErrors == 0 && countErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogCycles * 8);
		$display("timeout: the program did not reach its final jump within %0d cycles",
			watchdogCycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- bench/tbMemory.sv
// instruction and data memory models, random busy levels, store commit log
`timescale 1ns/1ps

module tbMemory #(
	parameter int seedInit = 91
) (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic busyEnable,
	input logic [29:0] imemAddr,
	input logic imemRen,
	output cpuPkg::word_t imemData,
	output logic imemBusy,
	input cpuPkg::dmemReq_t dmemReq,
	output cpuPkg::word_t dmemRdata,
	output logic dmemBusy,
	output logic wrFire,
	output logic [29:0] wrAddr,
	output cpuPkg::word_t wrData
);

	cpuPkg::word_t imem [128];
	cpuPkg::word_t dmem [64];
	integer busySeed;
	logic dmemCommit;

	initial begin
		busySeed = seedInit;
		imemBusy = 1'b0;
		dmemBusy = 1'b0;
		wrFire = 1'b0;
		wrAddr = '0;
		wrData = '0;
	end

	assign imemData = imemRen ? imem[imemAddr[6:0]] : '0;  // nop while not reading
	assign dmemRdata = dmem[dmemReq.addr[5:0]];
	assign dmemCommit = rst_n && dmemReq.wen && !dmemBusy;

	always @(posedge DCACHE_stall) begin
		if (busyEnable) begin
			imemBusy <= ($random(busySeed) & 3) == 0;  // about one cycle in four
			dmemBusy <= ($random(busySeed) & 3) == 0;
		end else begin
			imemBusy <= 1'b0;
			dmemBusy <= 1'b0;
		end
	end

	// one log entry per committed write, seen by the bench a cycle later
	always @(posedge DCACHE_stall) begin
		wrFire <= dmemCommit;
		wrAddr <= dmemReq.addr;
		wrData <= dmemReq.wdata;
		if (dmemCommit) begin
			dmem[dmemReq.addr[5:0]] <= dmemReq.wdata;
		end
	end

endmodule

//--- hw/cpuTop.sv
// five-stage pipeline top level, stage and pipeline register instances
`timescale 1ns/1ps

module cpuTop #(
	parameter cpuPkg::word_t resetPc = 32'h0
) (
	input logic DCACHE_stall,
	input logic rst_n,
	output logic [29:0] imemAddr,
	output logic imemRen,
	input cpuPkg::word_t imemData,
	input logic imemBusy,
	output cpuPkg::dmemReq_t dmemReq,
	input cpuPkg::word_t dmemRdata,
	input logic dmemBusy
);

	logic stall;
	logic stallDecode;
	cpuPkg::regIdx_t srcRs;
	cpuPkg::regIdx_t srcRt;
	logic usesRt;
	logic isBranch;
	cpuPkg::fwdSel_t fwdA;
	cpuPkg::fwdSel_t fwdB;
	cpuPkg::word_t memFwd;
	cpuPkg::idEx_t idD;
	cpuPkg::idEx_t idQ;
	cpuPkg::exMem_t exD;
	cpuPkg::exMem_t exQ;
	cpuPkg::memWb_t wbD;
	cpuPkg::memWb_t wbQ;

	assign stall = imemBusy | dmemBusy;

	fetchDecode #(
		.resetPc(resetPc)
	) u_fetchDecode (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.imemData(imemData),
		.imemBusy(stall),  // either memory busy freezes fetch
		.stallDecode(stallDecode),
		.wbStage(wbQ),
		.imemAddr(imemAddr),
		.imemRen(imemRen),
		.idOut(idD),
		.srcRs(srcRs),
		.srcRt(srcRt),
		.usesRt(usesRt),
		.isBranch(isBranch)
	);

	hazardUnit u_hazardUnit (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.stall(stall),
		.srcRs(srcRs),
		.srcRt(srcRt),
		.usesRt(usesRt),
		.isBranch(isBranch),
		.exDest(idQ.ctrl.dest),
		.exMemRead(idQ.ctrl.memRead),
		.memDest(exQ.dest),
		.stallDecode(stallDecode)
	);

	pipeReg #(.payload_t(cpuPkg::idEx_t)) u_idEx (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.hold(stall),
		.bubble(stallDecode),
		.d(idD),
		.q(idQ)
	);

	forwardUnit u_forwardUnit (
		.exRs(idQ.rs),
		.exRt(idQ.rt),
		.memStageTag(exQ.dest),
		.wbStageTag(wbQ.dest),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

	executeStage u_executeStage (
		.idIn(idQ),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.memFwd(memFwd),
		.wbFwd(wbQ.wbData),
		.exOut(exD)
	);

	pipeReg #(.payload_t(cpuPkg::exMem_t)) u_exMem (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.hold(stall),
		.bubble(1'b0),
		.d(exD),
		.q(exQ)
	);

	memStage u_memStage (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.stall(stall),
		.dmemBusy(dmemBusy),
		.exIn(exQ),
		.dmemRdata(dmemRdata),
		.dmemReq(dmemReq),
		.memFwd(memFwd),
		.wbOut(wbD)
	);

	pipeReg #(.payload_t(cpuPkg::memWb_t)) u_memWb (
		.DCACHE_stall(DCACHE_stall),
		.rst_n(rst_n),
		.hold(stall),
		.bubble(1'b0),
		.d(wbD),
		.q(wbQ)
	);

endmodule

//--- hw/fetchDecode.sv
// PC, instruction register, decoder, register file, branch compare, next PC
`timescale 1ns/1ps

module fetchDecode #(
	parameter cpuPkg::word_t resetPc = 32'h0
) (
	input logic DCACHE_stall,
	input logic rst_n,
	input cpuPkg::word_t imemData,
	input logic imemBusy,
	input logic stallDecode,
	input cpuPkg::memWb_t wbStage,
	output logic [29:0] imemAddr,
	output logic imemRen,
	output cpuPkg::idEx_t idOut,
	output cpuPkg::regIdx_t srcRs,
	output cpuPkg::regIdx_t srcRt,
	output logic usesRt,
	output logic isBranch
);

	logic [29:0] pcWord;
	cpuPkg::word_t ir;
	cpuPkg::word_t regs [32];
	cpuPkg::word_t rsVal;
	cpuPkg::word_t rtVal;
	cpuPkg::ctrl_t ctrl;
	cpuPkg::regIdx_t destRaw;
	logic writes;
	logic isJump;
	logic redirect;
	logic [29:0] nextPc;

	// write-through so decode sees the value retiring this cycle
	function automatic cpuPkg::word_t readReg(input cpuPkg::regIdx_t idx);
		if (idx == '0) begin
			return '0;
		end else if (wbStage.regWrite && wbStage.dest == idx) begin
			return wbStage.wbData;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge DCACHE_stall) begin
		if (wbStage.regWrite) begin
			regs[wbStage.dest] <= wbStage.wbData;
		end
	end

	always_comb begin
		ctrl = '0;
		destRaw = ir[20:16];
		writes = 1'b0;
		usesRt = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		case (ir[31:26])
			cpuPkg::opRtype: begin
				destRaw = ir[15:11];
				writes = 1'b1;
				usesRt = 1'b1;
			end
			cpuPkg::opAddi: begin
				ctrl.immKind = cpuPkg::immSext;
				writes = 1'b1;
			end
			cpuPkg::opSlti: begin
				ctrl.aluOp = cpuPkg::aluSlt;
				ctrl.immKind = cpuPkg::immSext;
				writes = 1'b1;
			end
			cpuPkg::opAndi: begin
				ctrl.aluOp = cpuPkg::aluAnd;
				ctrl.immKind = cpuPkg::immZext;
				writes = 1'b1;
			end
			cpuPkg::opOri: begin
				ctrl.aluOp = cpuPkg::aluOr;
				ctrl.immKind = cpuPkg::immZext;
				writes = 1'b1;
			end
			cpuPkg::opXori: begin
				ctrl.aluOp = cpuPkg::aluXor;
				ctrl.immKind = cpuPkg::immZext;
				writes = 1'b1;
			end
			cpuPkg::opLw: begin
				ctrl.immKind = cpuPkg::immSext;
				ctrl.memRead = 1'b1;
				writes = 1'b1;
			end
			cpuPkg::opSw: begin
				ctrl.immKind = cpuPkg::immSext;
				ctrl.memWrite = 1'b1;
				usesRt = 1'b1;
			end
			cpuPkg::opBeq: begin
				isBranch = 1'b1;
				usesRt = 1'b1;
			end
			cpuPkg::opJ: isJump = 1'b1;
			default: ;  // unknown opcode decodes as nop
		endcase
		ctrl.regWrite = writes && (destRaw != '0);  // writes to $0 are dropped here
		ctrl.dest = ctrl.regWrite ? destRaw : '0;
	end

	assign srcRs = isJump ? '0 : ir[25:21];
	assign srcRt = ir[20:16];
	assign rsVal = readReg(srcRs);
	assign rtVal = readReg(srcRt);

	assign redirect = isJump || (isBranch && rsVal == rtVal);

	always_comb begin
		if (isJump) begin
			nextPc = {pcWord[29:26], ir[25:0]};
		end else if (redirect) begin
			nextPc = pcWord + {{14{ir[15]}}, ir[15:0]};  // pcWord is already branch + 1
		end else begin
			nextPc = pcWord + 30'd1;
		end
	end

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			pcWord <= resetPc[31:2];
			ir <= '0;
			imemRen <= 1'b0;
		end else begin
			imemRen <= 1'b1;
			if (imemRen && !imemBusy && !stallDecode) begin
				pcWord <= nextPc;
				ir <= redirect ? '0 : imemData;  // squash the slot behind
			end
		end
	end

	assign imemAddr = pcWord;

	assign idOut.ctrl = ctrl;
	assign idOut.rs = srcRs;
	assign idOut.rt = srcRt;
	assign idOut.opA = rsVal;
	assign idOut.opB = rtVal;
	assign idOut.imm = {{16{ir[15]}}, ir[15:0]};

	a_noZeroWrite: assert property (@(posedge DCACHE_stall) disable iff (!rst_n)
		wbStage.regWrite |-> (wbStage.dest != '0));

endmodule

//--- hw/memStage.sv
// data memory request and writeback value select
`timescale 1ns/1ps

module memStage (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic stall,
	input logic dmemBusy,
	input cpuPkg::exMem_t exIn,
	input cpuPkg::word_t dmemRdata,
	output cpuPkg::dmemReq_t dmemReq,
	output cpuPkg::word_t memFwd,
	output cpuPkg::memWb_t wbOut
);

	logic storeTaken;

	// fetch busy can freeze us after the memory already took the store
	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			storeTaken <= 1'b0;
		end else if (!stall) begin
			storeTaken <= 1'b0;
		end else if (dmemReq.wen && !dmemBusy) begin
			storeTaken <= 1'b1;
		end
	end

	assign dmemReq.ren = exIn.memRead;
	assign dmemReq.wen = exIn.memWrite && !storeTaken;
	assign dmemReq.addr = exIn.result[31:2];
	assign dmemReq.wdata = exIn.storeData;

	assign memFwd = exIn.result;  // no load here when a consumer is in execute

	assign wbOut.regWrite = exIn.regWrite;
	assign wbOut.dest = exIn.dest;
	assign wbOut.wbData = exIn.memRead ? dmemRdata : exIn.result;

	a_oneAccess: assert property (@(posedge DCACHE_stall) disable iff (!rst_n)
		!(dmemReq.ren && dmemReq.wen));

endmodule

//--- hw/executeStage.sv
// ALU control, bypass and immediate operand muxes, ALU
`timescale 1ns/1ps

module executeStage (
	input cpuPkg::idEx_t idIn,
	input cpuPkg::fwdSel_t fwdA,
	input cpuPkg::fwdSel_t fwdB,
	input cpuPkg::word_t memFwd,
	input cpuPkg::word_t wbFwd,
	output cpuPkg::exMem_t exOut
);

	cpuPkg::word_t srcA;
	cpuPkg::word_t srcB;
	cpuPkg::word_t aluB;
	cpuPkg::word_t result;
	cpuPkg::aluOp_t op;

	function automatic cpuPkg::word_t bypass(
		input cpuPkg::fwdSel_t sel,
		input cpuPkg::word_t regVal,
		input cpuPkg::word_t memVal,
		input cpuPkg::word_t wbVal
	);
		case (sel)
			cpuPkg::fwdMem: return memVal;
			cpuPkg::fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = bypass(fwdA, idIn.opA, memFwd, wbFwd);
	assign srcB = bypass(fwdB, idIn.opB, memFwd, wbFwd);

	always_comb begin
		case (idIn.ctrl.immKind)
			cpuPkg::immSext: aluB = idIn.imm;
			cpuPkg::immZext: aluB = {16'b0, idIn.imm[15:0]};
			default: aluB = srcB;
		endcase
	end

	always_comb begin
		op = idIn.ctrl.aluOp;
		if (idIn.ctrl.immKind == cpuPkg::immReg) begin  // R-type, op from funct
			case (idIn.imm[5:0])
				cpuPkg::fnSub: op = cpuPkg::aluSub;
				cpuPkg::fnAnd: op = cpuPkg::aluAnd;
				cpuPkg::fnOr: op = cpuPkg::aluOr;
				cpuPkg::fnNor: op = cpuPkg::aluNor;
				cpuPkg::fnSlt: op = cpuPkg::aluSlt;
				default: op = cpuPkg::aluAdd;
			endcase
		end
	end

	always_comb begin
		case (op)
			cpuPkg::aluSub: result = srcA - aluB;
			cpuPkg::aluAnd: result = srcA & aluB;
			cpuPkg::aluOr: result = srcA | aluB;
			cpuPkg::aluXor: result = srcA ^ aluB;
			cpuPkg::aluNor: result = ~(srcA | aluB);
			cpuPkg::aluSlt: result = {31'b0, $signed(srcA) < $signed(aluB)};
			default: result = srcA + aluB;
		endcase
	end

	assign exOut.memRead = idIn.ctrl.memRead;
	assign exOut.memWrite = idIn.ctrl.memWrite;
	assign exOut.regWrite = idIn.ctrl.regWrite;
	assign exOut.dest = idIn.ctrl.dest;
	assign exOut.result = result;
	assign exOut.storeData = srcB;  // sw data takes the bypassed rt

endmodule

//--- hw/forwardUnit.sv
// bypass source selection for both execute operands
`timescale 1ns/1ps

module forwardUnit (
	input cpuPkg::regIdx_t exRs,
	input cpuPkg::regIdx_t exRt,
	input cpuPkg::regIdx_t memStageTag,
	input cpuPkg::regIdx_t wbStageTag,
	output cpuPkg::fwdSel_t fwdA,
	output cpuPkg::fwdSel_t fwdB
);

	function automatic cpuPkg::fwdSel_t pickSource(
		input cpuPkg::regIdx_t src,
		input cpuPkg::regIdx_t memTag,
		input cpuPkg::regIdx_t wbTag
	);
		if (src == '0) begin
			return cpuPkg::fwdNone;  // $0 is never bypassed
		end else if (src == memTag) begin
			return cpuPkg::fwdMem;  // youngest value first
		end else if (src == wbTag) begin
			return cpuPkg::fwdWb;
		end
		return cpuPkg::fwdNone;
	endfunction

	assign fwdA = pickSource(exRs, memStageTag, wbStageTag);
	assign fwdB = pickSource(exRt, memStageTag, wbStageTag);

endmodule

//--- hw/hazardUnit.sv
// load-use and branch operand interlock for the decode stage
`timescale 1ns/1ps

module hazardUnit (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic stall,
	input cpuPkg::regIdx_t srcRs,
	input cpuPkg::regIdx_t srcRt,
	input logic usesRt,
	input logic isBranch,
	input cpuPkg::regIdx_t exDest,
	input logic exMemRead,
	input cpuPkg::regIdx_t memDest,
	output logic stallDecode
);

	logic exHitsRs;
	logic exHitsRt;
	logic memHitsRs;
	logic memHitsRt;
	logic [1:0] holdRun;

	assign exHitsRs = (exDest != '0) && (exDest == srcRs);
	assign exHitsRt = usesRt && (exDest != '0) && (exDest == srcRt);
	assign memHitsRs = (memDest != '0) && (memDest == srcRs);
	assign memHitsRt = usesRt && (memDest != '0) && (memDest == srcRt);

	// beq compares in decode, so it waits until the source is in writeback
	assign stallDecode = (exMemRead && (exHitsRs || exHitsRt)) ||
		(isBranch && (exHitsRs || exHitsRt || memHitsRs || memHitsRt));

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			holdRun <= '0;
		end else if (!stall) begin
			holdRun <= stallDecode ? holdRun + {1'b0, holdRun != 2'd3} : 2'd0;  // saturating
		end
	end

	// a lw feeding a beq is the longest wait: two live cycles
	a_stallBounded: assert property (@(posedge DCACHE_stall) disable iff (!rst_n)
		(stallDecode && !stall) |-> (holdRun < 2'd2));

endmodule

//--- hw/pipeReg.sv
// stage register with freeze and bubble for any packed payload
`timescale 1ns/1ps

module pipeReg #(
	parameter type payload_t = logic [7:0]
) (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic hold,
	input logic bubble,
	input payload_t d,
	output payload_t q
);

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (!hold) begin  // hold wins over bubble
			if (bubble) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

//--- hw/cpuPkg.sv
// word and register types, opcode and funct encodings, control and stage payload structs
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;

	typedef enum logic [5:0] {
		opRtype = 6'd0,
		opJ     = 6'd2,
		opBeq   = 6'd4,
		opAddi  = 6'd8,
		opSlti  = 6'd10,
		opAndi  = 6'd12,
		opOri   = 6'd13,
		opXori  = 6'd14,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcode_t;

	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnNor = 6'd39,
		fnSlt = 6'd42
	} funct_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt
	} aluOp_t;

	typedef enum logic [1:0] {
		immReg,  // second operand from rt
		immSext,
		immZext
	} immKind_t;

	typedef enum logic [1:0] {
		fwdNone,
		fwdMem,
		fwdWb
	} fwdSel_t;

	typedef struct packed {
		aluOp_t aluOp;
		immKind_t immKind;
		logic memRead;
		logic memWrite;
		logic regWrite;
		regIdx_t dest;  // zero whenever regWrite is low
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		regIdx_t rs;
		regIdx_t rt;
		word_t opA;
		word_t opB;
		word_t imm;  // sign extended, funct sits in [5:0]
	} idEx_t;

	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic regWrite;
		regIdx_t dest;
		word_t result;
		word_t storeData;
	} exMem_t;

	typedef struct packed {
		logic regWrite;
		regIdx_t dest;
		word_t wbData;
	} memWb_t;

	typedef struct packed {
		logic ren;
		logic wen;
		logic [29:0] addr;  // word address
		word_t wdata;
	} dmemReq_t;

endpackage
